//--- dv/scope_capture_assert.sv
/*
 * Concurrent checks bound into scope_capture.
 * Ports connect by name to signals of the bound scope, internals included.
 * Failures are counted in failures for the testbench closing line.
 */
`timescale 1ns/1ps

module scope_capture_assert #(
    parameter int DATA_WIDTH = 16,
    parameter int DEST_WIDTH = 3,
    parameter int N_TRIGGERS = 8
) (
    input logic                  clock,
    input logic                  arst_n,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic [DATA_WIDTH-1:0] out_data,
    input logic [DEST_WIDTH-1:0] out_dest,
    input logic                  out_last,
    input logic                  reg_read,
    input logic                  reg_rvalid,
    input logic [N_TRIGGERS-1:0] trigger_out,
    input logic                  capture_en,
    input logic                  trigger_event
);

    int unsigned failures = 0;

    // A stalled output word keeps its valid, data and dest
    a_stall_hold: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_dest))
    else begin
        failures++;
        $error("output word changed while out_ready was low");
    end

    // Everything that leaves the core or pulses inside it is quiet in reset
    a_reset_state: assert property (@(posedge clock)
        !arst_n |-> !out_valid && !out_last && !reg_rvalid && (trigger_out == '0)
                    && !capture_en && !trigger_event)
    else begin
        failures++;
        $error("an output or pulse was high during reset");
    end

    // Read data is flagged exactly one cycle after the read request
    a_read_latency: assert property (@(posedge clock) disable iff (!arst_n)
        reg_rvalid == $past(reg_read))
    else begin
        failures++;
        $error("reg_rvalid did not follow reg_read by one cycle");
    end

    // A trigger output pulse drives a single line for a single cycle
    a_trigger_pulse: assert property (@(posedge clock) disable iff (!arst_n)
        trigger_out != '0 |-> $onehot(trigger_out) ##1 (trigger_out == '0))
    else begin
        failures++;
        $error("trigger_out was not a one-line, one-cycle pulse");
    end

endmodule

//--- dv/scope_capture_tb.sv
/*
 * Testbench for scope_capture: registers, merge, decimation, framing, triggers.
 * Inputs change on the falling edge; handshakes are sampled on the rising edge.
 * Sample word is {channel, sequence}, so every output word is checked by rule.
 */
`timescale 1ns/1ps

module scope_capture_tb import scope_pkg::*;;

    localparam int N_STREAMS  = 4;
    localparam int DATA_WIDTH = 16;
    localparam int N_TRIGGERS = 8;
    localparam int DEST_WIDTH = 3;
    localparam int SEQ_BITS   = DATA_WIDTH - 4;
    // Samples per channel and phase, a multiple of every decimation used
    localparam int SAMPLES    = 24;
    localparam int PERIOD     = 5;
    localparam int TPOS       = 2;
    localparam int SEL        = 3;
    // Cycle budget of each test, the run limit is twice their sum
    localparam int REG_TEST_CYCLES   = 80;
    localparam int STREAM_CYCLES     = N_STREAMS * SAMPLES * 4;
    localparam int TRIG_TEST_CYCLES  = 40;
    localparam int TIMEOUT = 2 * (8 + REG_TEST_CYCLES + 3 * STREAM_CYCLES + TRIG_TEST_CYCLES);

    logic                            clock;
    logic                            arst_n;
    logic [REG_ADDR_WIDTH-1:0]       reg_addr;
    logic [REG_WIDTH-1:0]            reg_wdata;
    logic                            reg_write;
    logic                            reg_read;
    logic [REG_WIDTH-1:0]            reg_rdata;
    logic                            reg_rvalid;
    logic [N_STREAMS*DATA_WIDTH-1:0] ch_data;
    logic [N_STREAMS-1:0]            ch_valid;
    logic [N_STREAMS-1:0]            ch_ready;
    logic [N_TRIGGERS-1:0]           ext_trigger;
    logic [N_TRIGGERS-1:0]           trigger_out;
    logic [DATA_WIDTH-1:0]           out_data;
    logic [DEST_WIDTH-1:0]           out_dest;
    logic                            out_last;
    logic                            out_valid;
    logic                            out_ready;

    logic [31:0]          lfsr = 32'h846e_3c0e;
    int                   sent_seq [N_STREAMS];
    int                   recv [N_STREAMS];
    logic [N_STREAMS-1:0] taken = '0;
    int                   decim = 0;
    int                   pos = 0;
    bit                   streaming = 0;
    bit                   drain = 0;
    bit                   expect_trigger = 0;
    bit                   triggered = 0;
    bit                   frame_done = 0;
    int unsigned          check_errors = 0;
    int unsigned          timeouts = 0;
    int unsigned          cycle_count = 0;

    scope_clock_gen #(.RESET_CYCLES(8)) u_clock_gen (.clock(clock), .arst_n(arst_n));

    scope_capture #(
        .N_STREAMS(N_STREAMS), .DATA_WIDTH(DATA_WIDTH),
        .N_TRIGGERS(N_TRIGGERS), .DEST_WIDTH(DEST_WIDTH)
    ) u_dut (.*);

    bind scope_capture scope_capture_assert #(
        .DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH), .N_TRIGGERS(N_TRIGGERS)
    ) u_assert (.*);

    // Galois LFSR, one step per random bit
    function automatic logic lfsr_bit();
        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        return lfsr[0];
    endfunction

    function automatic logic [DATA_WIDTH-1:0] sample_word(input int ch, input int seq);
        return DATA_WIDTH'((ch << SEQ_BITS) | (seq & ((1 << SEQ_BITS) - 1)));
    endfunction

    function automatic bit all_sent();
        for (int c = 0; c < N_STREAMS; c++) begin
            if (sent_seq[c] < SAMPLES) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("FAILED time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        end
    endtask

    task automatic write_reg(input int addr, input logic [31:0] data);
        @(negedge clock);
        reg_addr  = REG_ADDR_WIDTH'(addr);
        reg_wdata = data;
        reg_write = 1'b1;
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    // Data is due with reg_rvalid one cycle after the request
    task automatic read_check(input int addr, input logic [31:0] expected, input string name);
        @(negedge clock);
        reg_addr = REG_ADDR_WIDTH'(addr);
        reg_read = 1'b1;
        @(negedge clock);
        reg_read = 1'b0;
        check_equal("reg_rvalid", 32'd1, 32'(reg_rvalid));
        check_equal(name, expected, reg_rdata);
    endtask

    // The selected line pulses alone in the second cycle after the write
    task automatic fire_sw_trigger();
        write_reg(REG_SW_TRIGGER, 32'd1);
        check_equal("trigger_out", 32'd0, 32'(trigger_out));
        @(negedge clock);
        check_equal("trigger_out", 32'd1 << SEL, 32'(trigger_out));
        @(negedge clock);
        check_equal("trigger_out", 32'd0, 32'(trigger_out));
    endtask

    task automatic clear_counts();
        for (int c = 0; c < N_STREAMS; c++) begin
            sent_seq[c] = 0;
            recv[c]     = 0;
        end
    endtask

    // Streams SAMPLES per channel, then drains and counts the kept words
    task automatic run_stream(input int dec);
        write_reg(REG_DECIMATION, dec);
        decim = dec;
        clear_counts();
        streaming = 1'b1;
        while (!all_sent()) @(negedge clock);
        streaming = 1'b0;
        drain     = 1'b1;
        // At most N_STREAMS+1 words are in flight, one leaves per cycle
        repeat (N_STREAMS + 4) @(negedge clock);
        drain = 1'b0;
        for (int c = 0; c < N_STREAMS; c++) begin
            check_equal($sformatf("word count of channel %0d", c), SAMPLES / (dec + 1), recv[c]);
        end
    endtask

    task automatic finish_run();
        $display("errors: checks=%0d assertions=%0d timeouts=%0d",
                 check_errors, u_dut.u_assert.failures, timeouts);
        if (check_errors == 0 && u_dut.u_assert.failures == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // Input driver, a raised ch_valid holds until its sample is taken
    always @(negedge clock) begin
        for (int c = 0; c < N_STREAMS; c++) begin
            if (!ch_valid[c] || taken[c]) begin
                ch_valid[c] = streaming && (sent_seq[c] < SAMPLES) && lfsr_bit();
            end
            ch_data[c*DATA_WIDTH +: DATA_WIDTH] = sample_word(c, sent_seq[c]);
        end
        out_ready = drain || lfsr_bit();
    end

    // Handshake monitor, flop outputs still hold their pre-edge values here
    always @(posedge clock) begin
        cycle_count++;
        if (arst_n) begin
            for (int c = 0; c < N_STREAMS; c++) begin
                taken[c] = ch_valid[c] && ch_ready[c];
                if (taken[c]) sent_seq[c]++;
            end
            // The trigger pulse cycle counts as frame position TPOS
            if (expect_trigger && trigger_out != '0) begin
                pos            = TPOS;
                expect_trigger = 1'b0;
                triggered      = 1'b1;
            end
            assert (!(out_valid && frame_done)) else begin
                check_errors++;
                $display("ERROR: output word at %0t after the triggered frame ended", $time);
            end
            if (out_valid && out_ready) begin
                if (out_dest < N_STREAMS) begin
                    check_equal("out_data", sample_word(out_dest, recv[out_dest] * (decim + 1)),
                                out_data);
                    recv[out_dest]++;
                end else begin
                    check_errors++;
                    $display("ERROR: out_dest %0d at %0t names no channel", out_dest, $time);
                end
                check_equal("out_last", 32'(pos == PERIOD - 1), 32'(out_last));
                if (pos == PERIOD - 1 && triggered) begin
                    frame_done = 1'b1;
                    triggered  = 1'b0;
                end
                pos = (pos == PERIOD - 1) ? 0 : pos + 1;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT) @(posedge clock);
        timeouts++;
        $display("ERROR: run stopped after %0d cycles before the tests finished", cycle_count);
        finish_run();
    end

    initial begin
        reg_addr    = '0;
        reg_wdata   = '0;
        reg_write   = 1'b0;
        reg_read    = 1'b0;
        ch_data     = '0;
        ch_valid    = '0;
        ext_trigger = '0;
        out_ready   = 1'b0;
        clear_counts();
        @(posedge arst_n);
        // Register access while idle
        read_check(REG_STATUS, 32'(CAP_IDLE), "status after reset");
        write_reg(REG_PERIOD, PERIOD);
        write_reg(REG_SEL_TRIGGER, SEL);
        write_reg(REG_TRIGGER_POS, TPOS);
        write_reg(REG_DECIMATION, 7);
        read_check(REG_PERIOD, PERIOD, "period");
        read_check(REG_SEL_TRIGGER, SEL, "sel_trigger");
        read_check(REG_TRIGGER_POS, TPOS, "trigger_pos");
        read_check(REG_DECIMATION, 7, "decimation");
        fire_sw_trigger();
        write_reg(REG_CAPTURE_ACK, 32'd1);
        read_check(REG_SW_TRIGGER, 0, "sw_trigger");
        read_check(REG_CAPTURE_ACK, 0, "capture_ack");
        write_reg(REG_ENABLE, 32'd1);
        read_check(REG_ENABLE, 1, "enable");
        read_check(REG_STATUS, 32'(CAP_ARMED), "status after enable");
        // Free-running merge and framing, then with decimation
        run_stream(0);
        run_stream(2);
        // Software trigger in the middle of a stream
        write_reg(REG_DECIMATION, 0);
        decim = 0;
        clear_counts();
        streaming = 1'b1;
        repeat (10) @(negedge clock);
        expect_trigger = 1'b1;
        fire_sw_trigger();
        while (!frame_done) @(negedge clock);
        while (!all_sent()) @(negedge clock);
        streaming = 1'b0;
        repeat (4) @(negedge clock);
        read_check(REG_STATUS, 32'(CAP_DONE), "status after frame");
        write_reg(REG_CAPTURE_ACK, 32'd1);
        frame_done = 1'b0;
        read_check(REG_STATUS, 32'(CAP_ARMED), "status after ack");
        // External trigger, an unselected line first
        @(negedge clock);
        ext_trigger[5] = 1'b1;
        @(negedge clock);
        ext_trigger[5] = 1'b0;
        read_check(REG_STATUS, 32'(CAP_ARMED), "status after unselected edge");
        @(negedge clock);
        ext_trigger[SEL] = 1'b1;
        @(negedge clock);
        ext_trigger[SEL] = 1'b0;
        read_check(REG_STATUS, 32'(CAP_TRIGGERED), "status after selected edge");
        finish_run();
    end

endmodule

//--- dv/scope_clock_gen.sv
/*
 * Testbench clock of 10 ns and an active-low reset.
 * Reset is released on a falling edge after RESET_CYCLES rising edges.
 */
`timescale 1ns/1ps

module scope_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Release away from the rising edge so no flop sees it mid-update
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

//--- logic/channel_sampler.sv
/*
 * Decimator and one-entry holding register for one channel.
 * While capture_en is low the channel is drained and samples are dropped.
 * The decimation count restarts on the rising edge of capture_en.
 */
`timescale 1ns/1ps

module channel_sampler import scope_pkg::*; #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  capture_en,
    input  logic [REG_WIDTH-1:0]  decimation,
    input  logic [DATA_WIDTH-1:0] ch_data,
    input  logic                  ch_valid,
    input  logic                  held_ready,
    output logic                  ch_ready,
    output logic [DATA_WIDTH-1:0] held_data,
    output logic                  held_valid
);

    logic                 capture_en_q;
    logic                 start;
    logic [REG_WIDTH-1:0] dec_count;
    logic [REG_WIDTH-1:0] cur_count;
    logic                 accept;
    logic                 keep;
    logic                 held_full;
    logic                 drain;

    // First cycle of a capture window sees a zero count
    assign start     = capture_en && !capture_en_q;
    assign cur_count = start ? '0 : dec_count;

    assign held_valid = held_full && capture_en;
    assign drain      = held_valid && held_ready;
    // Only a full register that is not being emptied stalls the channel
    assign ch_ready   = !capture_en || !held_full || drain;
    assign accept     = ch_valid && ch_ready;
    // Keep the sample at count zero, drop the others
    assign keep       = accept && capture_en && (cur_count == '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            capture_en_q <= 1'b0;
            dec_count    <= '0;
            held_full    <= 1'b0;
        end else begin
            capture_en_q <= capture_en;
            if (accept && capture_en) begin
                dec_count <= (cur_count >= decimation) ? '0 : cur_count + 1'b1;
            end else if (start) begin
                dec_count <= '0;
            end
            // Leftover samples are flushed when capture stops
            if (!capture_en) begin
                held_full <= 1'b0;
            end else if (keep) begin
                held_full <= 1'b1;
            end else if (drain) begin
                held_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (keep) begin
            held_data <= ch_data;
        end
    end

endmodule

//--- logic/frame_tracker.sv
/*
 * Counts accepted output beats and flags the last beat of each frame.
 * A period of zero disables framing and out_last stays low.
 * trigger_event reloads the count with trigger_pos in the same cycle.
 */
`timescale 1ns/1ps

module frame_tracker import scope_pkg::*; (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic [REG_WIDTH-1:0] period,
    input  logic [REG_WIDTH-1:0] trigger_pos,
    input  logic                 trigger_event,
    input  logic                 comb_valid,
    input  logic                 out_ready,
    output logic                 out_last,
    output logic                 frame_end
);

    logic [REG_WIDTH-1:0] beat_count;
    logic [REG_WIDTH-1:0] cur_count;
    logic [REG_WIDTH-1:0] next_count;
    logic                 beat;
    logic                 at_end;

    assign beat = comb_valid && out_ready;

    // The trigger cycle already counts as position trigger_pos
    assign cur_count = trigger_event ? trigger_pos : beat_count;

    // A trigger_pos past the period still ends on the next beat
    assign at_end = (period != '0) && (cur_count >= period - 1'b1);

    assign out_last  = comb_valid && at_end;
    assign frame_end = beat && at_end;

    always_comb begin
        next_count = cur_count;
        if (beat) begin
            next_count = at_end ? '0 : cur_count + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            beat_count <= '0;
        end else begin
            beat_count <= next_count;
        end
    end

endmodule

//--- logic/sample_combiner.sv
/*
 * Round-robin merge of N_STREAMS holding registers into one stream.
 * DEST_WIDTH must hold clog2(N_STREAMS); dest carries the channel index.
 * One grant per cycle, the search starts just after the last winner.
 */
`timescale 1ns/1ps

module sample_combiner #(
    parameter int N_STREAMS  = 4,
    parameter int DATA_WIDTH = 16,
    parameter int DEST_WIDTH = 3
) (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic [N_STREAMS*DATA_WIDTH-1:0] held_data,
    input  logic [N_STREAMS-1:0]            held_valid,
    input  logic                            out_ready,
    output logic [N_STREAMS-1:0]            held_ready,
    output logic [DATA_WIDTH-1:0]           comb_data,
    output logic [DEST_WIDTH-1:0]           comb_dest,
    output logic                            comb_valid
);

    logic                  load_ok;
    logic                  grant_valid;
    logic [DEST_WIDTH-1:0] grant_idx;
    logic [DEST_WIDTH-1:0] last_grant;

    // Output register may take a new word when empty or being drained
    assign load_ok = !comb_valid || out_ready;

    // Scan all channels once, beginning one past the previous winner
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int i = 1; i <= N_STREAMS; i++) begin
            idx = int'(last_grant) + i;
            if (idx >= N_STREAMS) begin
                idx = idx - N_STREAMS;
            end
            if (!grant_valid && held_valid[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = DEST_WIDTH'(idx);
            end
        end
    end

    // Handshake back to the single winning sampler
    for (genvar g = 0; g < N_STREAMS; g++) begin : gen_ready
        assign held_ready[g] = load_ok && grant_valid && (grant_idx == DEST_WIDTH'(g));
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            comb_valid <= 1'b0;
            // Channel 0 wins first after reset
            last_grant <= DEST_WIDTH'(N_STREAMS - 1);
        end else if (load_ok) begin
            comb_valid <= grant_valid;
            if (grant_valid) begin
                last_grant <= grant_idx;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_ok && grant_valid) begin
            comb_data <= held_data[grant_idx*DATA_WIDTH +: DATA_WIDTH];
            comb_dest <= grant_idx;
        end
    end

endmodule

//--- logic/scope_capture.sv
/*
 * Capture core top level: registers, trigger hub, samplers, combiner, tracker.
 * Channel buses are flat, lane i at bits [i*DATA_WIDTH +: DATA_WIDTH].
 * DEST_WIDTH must be at least clog2(N_STREAMS).
 */
`timescale 1ns/1ps

module scope_capture import scope_pkg::*; #(
    parameter int N_STREAMS  = 4,
    parameter int DATA_WIDTH = 16,
    parameter int N_TRIGGERS = 8,
    parameter int DEST_WIDTH = 3
) (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic [REG_ADDR_WIDTH-1:0]       reg_addr,
    input  logic [REG_WIDTH-1:0]            reg_wdata,
    input  logic                            reg_write,
    input  logic                            reg_read,
    output logic [REG_WIDTH-1:0]            reg_rdata,
    output logic                            reg_rvalid,
    input  logic [N_STREAMS*DATA_WIDTH-1:0] ch_data,
    input  logic [N_STREAMS-1:0]            ch_valid,
    output logic [N_STREAMS-1:0]            ch_ready,
    input  logic [N_TRIGGERS-1:0]           ext_trigger,
    output logic [N_TRIGGERS-1:0]           trigger_out,
    output logic [DATA_WIDTH-1:0]           out_data,
    output logic [DEST_WIDTH-1:0]           out_dest,
    output logic                            out_last,
    output logic                            out_valid,
    input  logic                            out_ready
);

    logic [REG_WIDTH-1:0]            period;
    logic                            enable;
    logic [REG_WIDTH-1:0]            sel_trigger;
    logic [REG_WIDTH-1:0]            trigger_pos;
    logic [REG_WIDTH-1:0]            decimation;
    logic                            sw_trigger;
    logic                            capture_ack;
    capture_state_t                  state;
    logic                            capture_en;
    logic                            trigger_event;
    logic                            frame_end;
    logic [N_STREAMS*DATA_WIDTH-1:0] held_data;
    logic [N_STREAMS-1:0]            held_valid;
    logic [N_STREAMS-1:0]            held_ready;

    scope_regs u_regs (
        .clock(clock), .arst_n(arst_n),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .reg_write(reg_write), .reg_read(reg_read), .state(state),
        .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid),
        .period(period), .enable(enable), .sel_trigger(sel_trigger),
        .trigger_pos(trigger_pos), .decimation(decimation),
        .sw_trigger(sw_trigger), .capture_ack(capture_ack)
    );

    trigger_hub #(.N_TRIGGERS(N_TRIGGERS)) u_hub (
        .clock(clock), .arst_n(arst_n),
        .enable(enable), .sel_trigger(sel_trigger), .ext_trigger(ext_trigger),
        .sw_trigger(sw_trigger), .capture_ack(capture_ack), .frame_end(frame_end),
        .state(state), .capture_en(capture_en),
        .trigger_event(trigger_event), .trigger_out(trigger_out)
    );

    // One identical sampler per channel lane
    for (genvar s = 0; s < N_STREAMS; s++) begin : gen_sampler
        channel_sampler #(.DATA_WIDTH(DATA_WIDTH)) u_sampler (
            .clock(clock), .arst_n(arst_n),
            .capture_en(capture_en), .decimation(decimation),
            .ch_data(ch_data[s*DATA_WIDTH +: DATA_WIDTH]),
            .ch_valid(ch_valid[s]), .held_ready(held_ready[s]),
            .ch_ready(ch_ready[s]),
            .held_data(held_data[s*DATA_WIDTH +: DATA_WIDTH]),
            .held_valid(held_valid[s])
        );
    end

    // The combiner register is the output register of the core
    sample_combiner #(
        .N_STREAMS(N_STREAMS), .DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH)
    ) u_combiner (
        .clock(clock), .arst_n(arst_n),
        .held_data(held_data), .held_valid(held_valid), .out_ready(out_ready),
        .held_ready(held_ready),
        .comb_data(out_data), .comb_dest(out_dest), .comb_valid(out_valid)
    );

    frame_tracker u_tracker (
        .clock(clock), .arst_n(arst_n),
        .period(period), .trigger_pos(trigger_pos), .trigger_event(trigger_event),
        .comb_valid(out_valid), .out_ready(out_ready),
        .out_last(out_last), .frame_end(frame_end)
    );

endmodule

//--- logic/scope_pkg.sv
/*
 * Shared constants and types for the scope capture core.
 * Register offsets are word addresses on the simple register port.
 * All registers are REG_WIDTH bits wide.
 */
package scope_pkg;

    // Register data width and word address width of the register port
    localparam int unsigned REG_WIDTH      = 32;
    localparam int unsigned REG_ADDR_WIDTH = 3;

    // Frame length in accepted output beats
    localparam int REG_PERIOD      = 0;
    // Bit 0 enables capture
    localparam int REG_ENABLE      = 1;
    // Index of the external trigger line used to arm a capture
    localparam int REG_SEL_TRIGGER = 2;
    // Write only, a write fires the software trigger
    localparam int REG_SW_TRIGGER  = 3;
    // Write only, bit 0 = 1 acknowledges a finished capture
    localparam int REG_CAPTURE_ACK = 4;
    // Beats of the triggered frame placed before the trigger
    localparam int REG_TRIGGER_POS = 5;
    // One sample is kept out of every DECIMATION+1
    localparam int REG_DECIMATION  = 6;
    // Read only, capture state in bits 1:0
    localparam int REG_STATUS      = 7;

    // Capture state as seen by software through REG_STATUS
    typedef enum logic [1:0] {
        CAP_IDLE      = 2'd0,
        CAP_ARMED     = 2'd1,
        CAP_TRIGGERED = 2'd2,
        CAP_DONE      = 2'd3
    } capture_state_t;

endpackage

//--- logic/scope_regs.sv
/*
 * Control register bank with a simple synchronous port.
 * Writes land on the next edge; read data comes one cycle after reg_read.
 * Software trigger and capture acknowledge are one-cycle pulses.
 */
`timescale 1ns/1ps

module scope_regs import scope_pkg::*; (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic [REG_WIDTH-1:0]      reg_wdata,
    input  logic                      reg_write,
    input  logic                      reg_read,
    input  capture_state_t            state,
    output logic [REG_WIDTH-1:0]      reg_rdata,
    output logic                      reg_rvalid,
    output logic [REG_WIDTH-1:0]      period,
    output logic                      enable,
    output logic [REG_WIDTH-1:0]      sel_trigger,
    output logic [REG_WIDTH-1:0]      trigger_pos,
    output logic [REG_WIDTH-1:0]      decimation,
    output logic                      sw_trigger,
    output logic                      capture_ack
);

    logic [REG_WIDTH-1:0] rd_word;

    // Writable registers and the two self-clearing pulses
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            period      <= '0;
            enable      <= 1'b0;
            sel_trigger <= '0;
            trigger_pos <= '0;
            decimation  <= '0;
            sw_trigger  <= 1'b0;
            capture_ack <= 1'b0;
        end else begin
            // Pulses last one cycle unless a new write arrives
            sw_trigger  <= reg_write && (reg_addr == REG_ADDR_WIDTH'(REG_SW_TRIGGER));
            capture_ack <= reg_write && (reg_addr == REG_ADDR_WIDTH'(REG_CAPTURE_ACK))
                           && reg_wdata[0];
            if (reg_write) begin
                case (reg_addr)
                    REG_ADDR_WIDTH'(REG_PERIOD):      period      <= reg_wdata;
                    REG_ADDR_WIDTH'(REG_ENABLE):      enable      <= reg_wdata[0];
                    REG_ADDR_WIDTH'(REG_SEL_TRIGGER): sel_trigger <= reg_wdata;
                    REG_ADDR_WIDTH'(REG_TRIGGER_POS): trigger_pos <= reg_wdata;
                    REG_ADDR_WIDTH'(REG_DECIMATION):  decimation  <= reg_wdata;
                    default: ;
                endcase
            end
        end
    end

    // Read mux, the pulse registers always read back as zero
    always_comb begin
        case (reg_addr)
            REG_ADDR_WIDTH'(REG_PERIOD):      rd_word = period;
            REG_ADDR_WIDTH'(REG_ENABLE):      rd_word = {{(REG_WIDTH-1){1'b0}}, enable};
            REG_ADDR_WIDTH'(REG_SEL_TRIGGER): rd_word = sel_trigger;
            REG_ADDR_WIDTH'(REG_TRIGGER_POS): rd_word = trigger_pos;
            REG_ADDR_WIDTH'(REG_DECIMATION):  rd_word = decimation;
            REG_ADDR_WIDTH'(REG_STATUS):      rd_word = {{(REG_WIDTH-2){1'b0}}, state};
            default:                          rd_word = '0;
        endcase
    end

    // Read valid follows reg_read by exactly one cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_read;
        end
    end

    // Read data is only meaningful alongside reg_rvalid
    always_ff @(posedge clock) begin
        if (reg_read) begin
            reg_rdata <= rd_word;
        end
    end

endmodule

//--- logic/trigger_hub.sv
/*
 * Capture FSM with trigger selection and the trigger output lines.
 * ext_trigger must already be synchronous to clock; edges are found here.
 * A sel_trigger past N_TRIGGERS selects no line at all.
 */
`timescale 1ns/1ps

module trigger_hub import scope_pkg::*; #(
    parameter int N_TRIGGERS = 8
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [REG_WIDTH-1:0]  sel_trigger,
    input  logic [N_TRIGGERS-1:0] ext_trigger,
    input  logic                  sw_trigger,
    input  logic                  capture_ack,
    input  logic                  frame_end,
    output capture_state_t        state,
    output logic                  capture_en,
    output logic                  trigger_event,
    output logic [N_TRIGGERS-1:0] trigger_out
);

    localparam int SEL_W = (N_TRIGGERS > 1) ? $clog2(N_TRIGGERS) : 1;

    logic [N_TRIGGERS-1:0] ext_q;
    logic                  sel_ok;
    logic [SEL_W-1:0]      sel_idx;
    logic                  ext_rise;
    logic                  fire;

    assign sel_ok   = sel_trigger < N_TRIGGERS;
    assign sel_idx  = sel_trigger[SEL_W-1:0];
    assign ext_rise = sel_ok && ext_trigger[sel_idx] && !ext_q[sel_idx];
    assign fire     = (state == CAP_ARMED) && (ext_rise || sw_trigger);

    // Capture stops in the very cycle the triggered frame ends
    assign capture_en = (state == CAP_ARMED) || ((state == CAP_TRIGGERED) && !frame_end);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= CAP_IDLE;
            ext_q         <= '0;
            trigger_event <= 1'b0;
            trigger_out   <= '0;
        end else begin
            ext_q         <= ext_trigger;
            trigger_event <= enable && fire;
            // Software trigger is mirrored onto the selected line
            trigger_out   <= (sw_trigger && sel_ok) ? (N_TRIGGERS'(1) << sel_idx) : '0;
            if (!enable) begin
                state <= CAP_IDLE;
            end else begin
                case (state)
                    CAP_IDLE:      state <= CAP_ARMED;
                    CAP_ARMED:     if (fire) state <= CAP_TRIGGERED;
                    CAP_TRIGGERED: if (frame_end) state <= CAP_DONE;
                    CAP_DONE:      if (capture_ack) state <= CAP_ARMED;
                    default:       state <= CAP_IDLE;
                endcase
            end
        end
    end

endmodule

//--- scope_capture.f
logic/scope_pkg.sv
logic/scope_regs.sv
logic/channel_sampler.sv
logic/sample_combiner.sv
logic/frame_tracker.sv
logic/trigger_hub.sv
logic/scope_capture.sv
dv/scope_clock_gen.sv
dv/scope_capture_assert.sv
dv/scope_capture_tb.sv
